// File: verilog/ice_app_pkg.sv
package ice_app_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int unsigned word_w        = 16;         // Buffer and data-in word
    localparam int unsigned buf_depth     = 256;        // One SD block of 512 bytes
    localparam int unsigned buf_addr_w    = $clog2(buf_depth);
    localparam int unsigned msg_type_w    = 8;
    localparam int unsigned msg_arg_w     = 56;
    localparam int unsigned msg_len       = msg_type_w + msg_arg_w;
    localparam int unsigned resp_len      = 64;

    // Block word that carries the CMD6 access mode in bits 11:8
    localparam int unsigned cmd6_word_idx = 8;

    // ====================
    // Message types
    // ====================
    localparam logic [msg_type_w-1:0] msg_nop     = 8'd0;
    localparam logic [msg_type_w-1:0] msg_echo    = 8'd1;
    localparam logic [msg_type_w-1:0] msg_led_set = 8'd2;
    localparam logic [msg_type_w-1:0] msg_status  = 8'd3;
    localparam logic [msg_type_w-1:0] msg_readout = 8'd4;

    // ====================
    // Structs
    // ====================

    // Host message as shifted in, MSB first
    typedef struct packed {
        logic [msg_type_w-1:0] msg_type;    // Top byte
        logic [msg_arg_w-1:0]  arg;
    } spi_msg_t;

    // One buffer access from either peer
    typedef struct packed {
        logic                  valid;
        logic                  write;       // 0 for a read
        logic [buf_addr_w-1:0] addr;
        logic [word_w-1:0]     wdata;
    } buf_req_t;

    // Block state reported by Status
    typedef struct packed {
        logic                  full;
        logic [3:0]            access_mode; // CMD6 nibble
        logic [buf_addr_w:0]   word_count;  // Up to buf_depth
    } blk_status_t;

endpackage

// File: verilog/buffer_ram.sv
`timescale 1ns/100ps

module buffer_ram import ice_app_pkg::*; (
    input  logic              sd_datInWrite_clk,
    input  buf_req_t          ram_req,
    output logic [word_w-1:0] ram_rdata
);
    logic [word_w-1:0] mem [buf_depth];

    // Write-first, so a write also returns the new word
    always_ff @(posedge sd_datInWrite_clk) begin
        if (ram_req.valid) begin
            if (ram_req.write) begin
                mem[ram_req.addr] <= ram_req.wdata;
                ram_rdata         <= ram_req.wdata;
            end else begin
                ram_rdata <= mem[ram_req.addr];  // Ready next cycle
            end
        end
    end

endmodule

// File: verilog/buffer_arbiter.sv
`timescale 1ns/100ps

module buffer_arbiter import ice_app_pkg::*; (
    input  buf_req_t          wr_req,
    input  buf_req_t          rd_req,
    input  logic [word_w-1:0] ram_rdata,
    output logic              wr_grant,
    output logic              rd_grant,
    output buf_req_t          ram_req,
    output logic [word_w-1:0] rd_data
);
    // ====================
    // Fixed priority
    // ====================

    // Block writer cannot stall, so it always wins
    assign wr_grant = wr_req.valid;
    assign rd_grant = rd_req.valid && !wr_req.valid;  // Reader retries until granted

    always_comb begin
        if (wr_grant) begin
            ram_req = wr_req;
        end else if (rd_grant) begin
            ram_req = rd_req;
        end else begin
            ram_req = '0;  // Idle
        end
    end

    // Only the reader consumes read data
    assign rd_data = ram_rdata;

endmodule

// File: verilog/sd_block_writer.sv
`timescale 1ns/100ps

module sd_block_writer import ice_app_pkg::*; (
    input  logic              sd_datInWrite_clk,
    input  logic              spi_rst_,
    input  logic              dat_in_start,
    input  logic              dat_in_trigger,
    input  logic [word_w-1:0] dat_in_data,
    input  logic              readout_done,
    output logic              dat_in_ready,
    output buf_req_t          wr_req,
    output blk_status_t       blk_status
);
    logic [buf_addr_w:0] word_cnt;     // Words taken in this block
    logic                full;
    logic [3:0]          access_mode;
    logic                accept;

    // Hold off the SD side until the block is read out
    assign dat_in_ready = !full;
    assign accept       = dat_in_trigger && dat_in_ready;

    // Each accepted word goes straight to the buffer
    always_comb begin
        wr_req.valid = accept;
        wr_req.write = 1'b1;
        wr_req.addr  = word_cnt[buf_addr_w-1:0];
        wr_req.wdata = dat_in_data;
    end

    always_comb begin
        blk_status.full        = full;
        blk_status.access_mode = access_mode;
        blk_status.word_count  = word_cnt;
    end

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_cnt    <= '0;
            full        <= 1'b0;
            access_mode <= '0;
        end else begin
            if (dat_in_start) begin
                word_cnt <= '0;  // New block
                full     <= 1'b0;
            end else begin
                if (accept) begin
                    word_cnt <= word_cnt + 1'b1;
                end
                if (accept && word_cnt[buf_addr_w-1:0] == '1) begin
                    full <= 1'b1;  // Last word of the block
                end else if (readout_done) begin
                    full <= 1'b0;
                end
            end

            // CMD6 status block
            if (accept && word_cnt == cmd6_word_idx) begin
                access_mode <= dat_in_data[11:8];
            end
        end
    end

endmodule

// File: verilog/spi_msg_engine.sv
`timescale 1ns/100ps

module spi_msg_engine import ice_app_pkg::*; (
    input  logic              sd_datInWrite_clk,
    input  logic              spi_rst_,
    input  logic              spi_data_in,
    input  blk_status_t       blk_status,
    input  logic              rd_grant,
    input  logic [word_w-1:0] rd_data,
    output logic              spi_data_out,
    output logic              spi_data_out_en,
    output logic [3:0]        led,
    output buf_req_t          rd_req,
    output logic              readout_done
);
    typedef enum logic [2:0] {
        st_idle,        // Waiting for start bit
        st_msg_in,
        st_decode,
        st_resp,
        st_readout
    } state_t;

    state_t              state;
    logic [6:0]          bit_cnt;       // Message in, response out
    spi_msg_t            msg_sr;
    logic [resp_len-1:0] resp_sr;

    // ====================
    // Readout
    // ====================
    logic [buf_addr_w:0] fetch_cnt;     // Next address to fetch
    logic [buf_addr_w:0] words_sent;
    logic [3:0]          word_bits;     // Bits left in current word
    logic                data_due;      // RAM data lands this cycle
    logic                pre_valid;     // Prefetched word waiting
    logic [word_w-1:0]   pre_word;
    logic [word_w-1:0]   word_sr;
    logic                rd_fetch;
    logic                word_load;

    // Fetch the next word while the current one shifts out
    assign rd_fetch  = (state == st_readout) && !fetch_cnt[buf_addr_w] && !pre_valid && !data_due;
    assign word_load = (state == st_readout) && (word_bits == '0) && pre_valid;

    always_comb begin
        rd_req       = '0;
        rd_req.valid = rd_fetch;
        rd_req.addr  = fetch_cnt[buf_addr_w-1:0];
    end

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state           <= st_idle;
            bit_cnt         <= '0;
            led             <= '0;
            spi_data_out    <= 1'b0;
            spi_data_out_en <= 1'b0;
            readout_done    <= 1'b0;
            fetch_cnt       <= '0;
            words_sent      <= '0;
            word_bits       <= '0;
            data_due        <= 1'b0;
            pre_valid       <= 1'b0;
        end else begin
            spi_data_out_en <= 1'b0;
            readout_done    <= 1'b0;
            case (state)
                st_idle: begin
                    if (spi_data_in) begin
                        bit_cnt <= 7'(msg_len);
                        state   <= st_msg_in;
                    end
                end
                st_msg_in: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == 7'd1) state <= st_decode;
                end
                st_decode: begin
                    state <= st_idle;
                    case (msg_sr.msg_type)
                        msg_echo, msg_status: begin
                            bit_cnt <= 7'(resp_len);
                            state   <= st_resp;
                        end
                        msg_led_set: led <= msg_sr.arg[3:0];
                        msg_readout: begin
                            fetch_cnt  <= '0;
                            words_sent <= '0;
                            word_bits  <= '0;
                            state      <= st_readout;
                        end
                        default: ;  // Nop and unknown types
                    endcase
                end
                st_resp: begin
                    if (bit_cnt != '0) begin
                        spi_data_out_en <= 1'b1;
                        spi_data_out    <= resp_sr[resp_len-1];
                        bit_cnt         <= bit_cnt - 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_readout: begin
                    if (rd_fetch && rd_grant) fetch_cnt <= fetch_cnt + 1'b1;
                    data_due <= rd_fetch && rd_grant;
                    if (data_due) begin
                        pre_valid <= 1'b1;
                    end else if (word_load) begin
                        pre_valid <= 1'b0;
                    end
                    if (word_load) begin
                        spi_data_out_en <= 1'b1;
                        spi_data_out    <= pre_word[word_w-1];  // MSB goes out on load
                        word_bits       <= 4'(word_w - 1);
                        words_sent      <= words_sent + 1'b1;
                    end else if (word_bits != '0) begin
                        spi_data_out_en <= 1'b1;
                        spi_data_out    <= word_sr[word_w-1];
                        word_bits       <= word_bits - 1'b1;
                    end else if (words_sent[buf_addr_w]) begin
                        readout_done <= 1'b1;  // Last bit just went out
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == st_msg_in) msg_sr <= {msg_sr[msg_len-2:0], spi_data_in};
        if (state == st_decode) begin
            if (msg_sr.msg_type == msg_echo) begin
                resp_sr <= {msg_echo, msg_sr.arg};
            end else begin
                resp_sr <= resp_len'(blk_status);
            end
        end else if (state == st_resp) begin
            resp_sr <= {resp_sr[resp_len-2:0], 1'b0};
        end
        if (data_due) pre_word <= rd_data;
        if (word_load) begin
            word_sr <= {pre_word[word_w-2:0], 1'b0};
        end else if (word_bits != '0) begin
            word_sr <= {word_sr[word_w-2:0], 1'b0};
        end
    end

endmodule

// File: verilog/ice_app.sv
`timescale 1ns/100ps

module ice_app import ice_app_pkg::*; (
    input  logic              sd_datInWrite_clk,
    input  logic              spi_rst_,
    input  logic              spi_data_in,
    input  logic              dat_in_start,
    input  logic              dat_in_trigger,
    input  logic [word_w-1:0] dat_in_data,
    output logic              dat_in_ready,
    output logic              spi_data_out,
    output logic              spi_data_out_en,
    output logic [3:0]        led
);
    blk_status_t       blk_status;
    buf_req_t          wr_req;
    buf_req_t          rd_req;
    buf_req_t          ram_req;
    logic              rd_grant;
    logic              readout_done;
    logic [word_w-1:0] rd_data;
    logic [word_w-1:0] ram_rdata;

    // ====================
    // Buffer peers
    // ====================
    spi_msg_engine u_engine (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .spi_data_in       (spi_data_in),
        .blk_status        (blk_status),
        .rd_grant          (rd_grant),
        .rd_data           (rd_data),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en),
        .led               (led),
        .rd_req            (rd_req),
        .readout_done      (readout_done)
    );

    sd_block_writer u_writer (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .dat_in_start      (dat_in_start),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data),
        .readout_done      (readout_done),
        .dat_in_ready      (dat_in_ready),
        .wr_req            (wr_req),
        .blk_status        (blk_status)
    );

    // ====================
    // Shared buffer
    // ====================
    buffer_arbiter u_arbiter (
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .ram_rdata (ram_rdata),
        .wr_grant  (),              // Writer is never held off
        .rd_grant  (rd_grant),
        .ram_req   (ram_req),
        .rd_data   (rd_data)
    );

    buffer_ram u_ram (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .ram_req           (ram_req),
        .ram_rdata         (ram_rdata)
    );

endmodule

// File: verification/ice_app_tb.sv
`timescale 1ns/100ps

module ice_app_tb import ice_app_pkg::*; ();
    logic              sd_datInWrite_clk;
    logic              spi_rst_;
    logic              spi_data_in;
    logic              dat_in_start;
    logic              dat_in_trigger;
    logic [word_w-1:0] dat_in_data;
    logic              dat_in_ready;
    logic              spi_data_out;
    logic              spi_data_out_en;
    logic [3:0]        led;

    integer            seed = 32'h68b8_e13e;
    logic [3:0]        exp_led;                 // Reference model
    logic [3:0]        exp_mode;
    logic              exp_full;
    logic [word_w-1:0] blk [buf_depth];
    logic [word_w-1:0] old_blk [buf_depth];     // Block before the last dat_in_start
    logic [word_w-1:0] rd_words [buf_depth];
    time               wr_t [buf_depth];        // Edge that drove each block word
    time               word_t [buf_depth];      // First enabled bit of each readout word
    time               msg_end_t;               // Edge that drove the last message bit

    ice_app u_dut (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic bad_value(input string what);
        fail_run($sformatf("ERR at %0t: %s", $time, what));
    endtask

    // ====================
    // Host side
    // ====================
    task automatic send_msg(input spi_msg_t m);
        @(posedge sd_datInWrite_clk) spi_data_in <= 1'b1;  // Start bit
        for (int i = msg_len - 1; i >= 0; i--) begin
            @(posedge sd_datInWrite_clk) spi_data_in <= m[i];
        end
        msg_end_t = $time;
        @(posedge sd_datInWrite_clk) spi_data_in <= 1'b0;
    endtask

    // First response bit is due two cycles after the last message bit
    task automatic expect_resp(input logic [resp_len-1:0] exp);
        logic [resp_len-1:0] got;
        repeat (2) begin
            @(negedge sd_datInWrite_clk);
            assert (!spi_data_out_en) else bad_value("response started early");
        end
        for (int i = resp_len - 1; i >= 0; i--) begin
            @(negedge sd_datInWrite_clk);
            assert (spi_data_out_en) else bad_value("response enable low too soon");
            got[i] = spi_data_out;
        end
        @(negedge sd_datInWrite_clk);
        assert (!spi_data_out_en) else bad_value("response longer than 64 bits");
        assert (got == exp) else bad_value($sformatf("response %h, expected %h", got, exp));
    endtask

    task automatic expect_quiet();
        repeat (resp_len + 8) begin
            @(negedge sd_datInWrite_clk);
            assert (!spi_data_out_en) else bad_value("enabled bit with no response due");
        end
        assert (led == exp_led) else bad_value($sformatf("led %h, expected %h", led, exp_led));
    endtask

    task automatic check_status();
        spi_msg_t m;
        m          = '0;
        m.msg_type = msg_status;
        send_msg(m);
        expect_resp(resp_len'({exp_full, exp_mode, 9'(buf_depth)}));
    endtask

    // ====================
    // SD data-in side
    // ====================
    task automatic send_block(input int gap_max);
        logic [31:0] rnd;
        @(posedge sd_datInWrite_clk) dat_in_start <= 1'b1;
        @(posedge sd_datInWrite_clk) dat_in_start <= 1'b0;
        old_blk  = blk;
        exp_full = 1'b0;
        for (int i = 0; i < buf_depth; i++) begin
            rnd = $random(seed);
            repeat (rnd[31:16] % (gap_max + 1)) begin
                @(posedge sd_datInWrite_clk) dat_in_trigger <= 1'b0;
            end
            @(posedge sd_datInWrite_clk);
            dat_in_trigger <= 1'b1;
            dat_in_data    <= rnd[word_w-1:0];
            wr_t[i] = $time;
            blk[i]  = rnd[word_w-1:0];
            if (i == cmd6_word_idx) exp_mode = rnd[11:8];  // CMD6 nibble
            @(negedge sd_datInWrite_clk);
            assert (dat_in_ready) else bad_value($sformatf("dat_in_ready low at word %0d", i));
        end
        @(posedge sd_datInWrite_clk) dat_in_trigger <= 1'b0;
        exp_full = 1'b1;
    endtask

    task automatic collect_readout();
        int nbits;
        int idle;
        nbits = 0;
        idle  = 0;
        while (nbits < buf_depth * word_w) begin
            @(negedge sd_datInWrite_clk);
            if (spi_data_out_en) begin
                if (nbits % word_w == 0) word_t[nbits / word_w] = $time;
                rd_words[nbits / word_w][word_w - 1 - nbits % word_w] = spi_data_out;
                nbits++;
                idle = 0;
            end else begin
                assert (nbits % word_w == 0) else bad_value("gap inside a readout word");
                idle++;
                assert (idle < 1000) else fail_run("Readout stalled, no data bit for 1000 cycles");
            end
        end
        // Nothing may follow the last bit
        repeat (resp_len) begin
            @(negedge sd_datInWrite_clk);
            assert (!spi_data_out_en) else bad_value("enabled bit after the end of readout");
        end
    endtask

    // With overlap, a word written close to its read may show either block
    task automatic check_readout(input bit overlap);
        time new_lim;
        bit  ok;
        for (int a = 0; a < buf_depth; a++) begin
            new_lim = (a == 0) ? msg_end_t : word_t[a-1] - 60;  // Read starts after prior load
            if (!overlap || wr_t[a] <= new_lim) begin
                ok = rd_words[a] == blk[a];
            end else if (wr_t[a] > word_t[a] - 40) begin
                ok = rd_words[a] == old_blk[a];  // Written after the read
            end else begin
                ok = rd_words[a] == blk[a] || rd_words[a] == old_blk[a];
            end
            assert (ok) else bad_value($sformatf("readout word %0d is %h, expected %h",
                                                 a, rd_words[a], blk[a]));
        end
    endtask

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #20 sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    initial begin
        int limit;
        // 40 message exchanges, two fast blocks, one slow block and two readouts
        limit = 40 * 200 + 2 * buf_depth * 5 + buf_depth * 33 + 2 * buf_depth * 40;
        #(limit * 2 * 40);
        fail_run($sformatf("Timeout, the run did not finish within %0d cycles", limit * 2));
    end

    initial begin
        spi_msg_t    m;
        logic [63:0] rnd64;
        spi_rst_       = 1'b0;
        spi_data_in    = 1'b0;
        dat_in_start   = 1'b0;
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        exp_led        = '0;
        exp_mode       = '0;
        exp_full       = 1'b0;
        repeat (4) @(posedge sd_datInWrite_clk);
        spi_rst_ <= 1'b1;
        @(negedge sd_datInWrite_clk);
        assert (dat_in_ready && !spi_data_out_en && led == 4'd0)
            else bad_value("outputs not at their reset values");

        // ==================== Random messages
        for (int n = 0; n < 24; n++) begin
            rnd64 = {$random(seed), $random(seed)};
            m.arg = rnd64[msg_arg_w-1:0];
            case (rnd64[63:62])
                2'd0:    m.msg_type = msg_echo;
                2'd1:    m.msg_type = msg_led_set;
                2'd2:    m.msg_type = msg_nop;
                default: m.msg_type = {1'b1, rnd64[62:56]};  // Unknown code
            endcase
            send_msg(m);
            if (m.msg_type == msg_echo) begin
                expect_resp({msg_echo, m.arg});
            end else begin
                if (m.msg_type == msg_led_set) exp_led = m.arg[3:0];
                expect_quiet();
            end
        end

        // ==================== Capture, back-pressure and readout
        send_block(3);
        repeat (4) begin
            @(posedge sd_datInWrite_clk) dat_in_trigger <= 1'b1;
            @(negedge sd_datInWrite_clk);
            assert (!dat_in_ready) else bad_value("dat_in_ready high with the block full");
        end
        @(posedge sd_datInWrite_clk) dat_in_trigger <= 1'b0;
        check_status();
        m = {msg_readout, rnd64[msg_arg_w-1:0]};
        send_msg(m);
        collect_readout();
        check_readout(1'b0);
        exp_full = 1'b0;  // Cleared by the end of readout
        check_status();
        send_block(3);
        check_status();

        // ==================== Readout racing a new block
        fork
            send_block(31);
            begin
                repeat (8) @(posedge sd_datInWrite_clk);
                send_msg(m);
                collect_readout();
            end
        join
        check_readout(1'b1);

        // Status and Readout leave the last LED setting alone
        @(negedge sd_datInWrite_clk);
        assert (led == exp_led) else bad_value($sformatf("led %h, expected %h", led, exp_led));

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: ice_app.f
verilog/ice_app_pkg.sv
verilog/buffer_ram.sv
verilog/buffer_arbiter.sv
verilog/sd_block_writer.sv
verilog/spi_msg_engine.sv
verilog/ice_app.sv
verification/ice_app_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ice_app testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ice_app_tb -f ice_app.f -o ice_app_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ice_app_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TEST RESULT: FAIL" "$log"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
